//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_controller_standby
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

//--- design/bus_monitor.sv
// I2C receive monitor that never stretches SCL and needs every SCL phase to last several clocks
`timescale 1ns/10ps
`default_nettype none

module bus_monitor (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           scl_i,
  input  logic                           sda_i,
  input  logic                           fifo_almost_full_i,
  output logic                           sda_o,
  output logic                           entry_push_o,
  output logic [standby_pkg::EntryW-1:0] entry_data_o,
  output logic                           bus_start_o,
  output logic                           bus_stop_o,
  output logic [7:0]                     bus_addr_o,
  output logic                           bus_addr_valid_o
);
  import standby_pkg::*;

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_d_q;
  logic       sda_d_q;

  logic scl_s;
  logic sda_s;
  logic scl_rise;
  logic scl_fall;
  logic start_det;
  logic stop_det;

  mon_state_e        state_q;
  logic [3:0]        bit_cnt_q;
  logic [6:0]        shift_q;
  logic              ack_q;
  logic              wr_active_q;
  logic              refused_q;
  logic              sda_q;
  logic              push_q;
  logic [EntryW-1:0] entry_data_q;
  logic              bus_start_q;
  logic              bus_stop_q;
  logic [7:0]        bus_addr_q;
  logic              addr_valid_q;

  logic       shifting;
  logic       last_bit;
  logic [7:0] rx_byte;
  logic       byte_ok;

  // Two-flop synchronizers, idle-high reset to avoid false edges
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_d_q    <= 1'b1;
      sda_d_q    <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_d_q    <= scl_sync_q[1];
      sda_d_q    <= sda_sync_q[1];
    end
  end

  assign scl_s     = scl_sync_q[1];
  assign sda_s     = sda_sync_q[1];
  assign scl_rise  = scl_s & ~scl_d_q;
  assign scl_fall  = ~scl_s & scl_d_q;
  // SDA moving while SCL stays high
  assign start_det = scl_s & scl_d_q & sda_d_q & ~sda_s;
  assign stop_det  = scl_s & scl_d_q & ~sda_d_q & sda_s;

  assign shifting = (state_q == MON_ADDR) || (state_q == MON_DATA);
  assign last_bit = shifting && scl_rise && (bit_cnt_q == 4'd7);
  assign rx_byte  = {shift_q, sda_s};

  // Header needs two free slots, one of them kept for the END entry
  assign byte_ok = !fifo_almost_full_i && ((state_q == MON_DATA) || !rx_byte[0]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= MON_IDLE;
      bit_cnt_q    <= '0;
      ack_q        <= 1'b0;
      wr_active_q  <= 1'b0;
      refused_q    <= 1'b0;
      sda_q        <= 1'b1;
      push_q       <= 1'b0;
      bus_start_q  <= 1'b0;
      bus_stop_q   <= 1'b0;
      addr_valid_q <= 1'b0;
    end else begin
      push_q       <= 1'b0;
      addr_valid_q <= 1'b0;
      bus_start_q  <= start_det;
      bus_stop_q   <= stop_det;
      if (start_det || stop_det) begin
        // Close any open write transfer with an END entry
        push_q      <= wr_active_q;
        wr_active_q <= 1'b0;
        refused_q   <= 1'b0;
        sda_q       <= 1'b1;
        bit_cnt_q   <= '0;
        state_q     <= start_det ? MON_ADDR : MON_IDLE;
      end else begin
        unique case (state_q)
          MON_ADDR, MON_DATA: begin
            if (scl_rise && !bit_cnt_q[3]) begin
              bit_cnt_q <= bit_cnt_q + 4'd1;
              if (last_bit) begin
                ack_q  <= byte_ok;
                push_q <= byte_ok;
                if (state_q == MON_ADDR) begin
                  addr_valid_q <= 1'b1;
                  wr_active_q  <= byte_ok;
                end else if (!byte_ok) begin
                  refused_q <= 1'b1;
                end
              end
            end else if (scl_fall && bit_cnt_q[3]) begin
              bit_cnt_q <= '0;
              if (state_q == MON_DATA) begin
                state_q <= MON_DATA_ACK;
                sda_q   <= !ack_q;
              end else if (ack_q) begin
                state_q <= MON_ADDR_ACK;
                sda_q   <= 1'b0;
              end else begin
                state_q <= MON_IGNORE;
              end
            end
          end
          MON_ADDR_ACK, MON_DATA_ACK: begin
            // Falling SCL after the ninth bit ends the ACK slot
            if (scl_fall) begin
              sda_q   <= 1'b1;
              state_q <= MON_DATA;
            end
          end
          // Idle and ignore wait for the next START or STOP
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (shifting && scl_rise) begin
      shift_q <= rx_byte[6:0];
    end
    if (start_det || stop_det) begin
      entry_data_q <= {ENTRY_END, 7'd0, refused_q};
    end else if (last_bit) begin
      entry_data_q <= {ENTRY_DATA, rx_byte};
    end
    if (last_bit && (state_q == MON_ADDR)) begin
      bus_addr_q <= rx_byte;
    end
  end

  assign sda_o            = sda_q;
  assign entry_push_o     = push_q;
  assign entry_data_o     = entry_data_q;
  assign bus_start_o      = bus_start_q;
  assign bus_stop_o       = bus_stop_q;
  assign bus_addr_o       = bus_addr_q;
  assign bus_addr_valid_o = addr_valid_q;

  a_sda_low_in_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !sda_o |-> (state_q inside {MON_ADDR_ACK, MON_DATA_ACK}));

endmodule

`default_nettype wire

//--- design/controller_standby.sv
// Receive-only I2C standby target that acks every write header and never answers a read
`timescale 1ns/10ps
`default_nettype none

module controller_standby (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  // Bus lines, SDA output is open-drain intent
  input  logic                              ctrl_scl_i,
  input  logic                              ctrl_sda_i,
  output logic                              ctrl_sda_o,

  // TTI RX data
  output logic                              rx_queue_wvalid_o,
  input  logic                              rx_queue_wready_i,
  output logic [7:0]                        rx_queue_wdata_o,

  // TTI RX descriptor
  output logic                              rx_desc_queue_wvalid_o,
  input  logic                              rx_desc_queue_wready_i,
  output logic [standby_pkg::DescDataW-1:0] rx_desc_queue_wdata_o,

  // Bus conditions and received header
  output logic                              bus_start_o,
  output logic                              bus_stop_o,
  output logic [7:0]                        bus_addr_o,
  output logic                              bus_addr_valid_o
);
  import standby_pkg::*;

  logic              entry_push;
  logic [EntryW-1:0] entry_data;
  logic              fifo_almost_full;
  logic [EntryW-1:0] head_data;
  logic              head_valid;
  logic              pop;

  bus_monitor u_bus_monitor (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .scl_i              (ctrl_scl_i),
    .sda_i              (ctrl_sda_i),
    .fifo_almost_full_i (fifo_almost_full),
    .sda_o              (ctrl_sda_o),
    .entry_push_o       (entry_push),
    .entry_data_o       (entry_data),
    .bus_start_o        (bus_start_o),
    .bus_stop_o         (bus_stop_o),
    .bus_addr_o         (bus_addr_o),
    .bus_addr_valid_o   (bus_addr_valid_o)
  );

  rx_fifo u_rx_fifo (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (entry_push),
    .push_data_i   (entry_data),
    .pop_i         (pop),
    .head_data_o   (head_data),
    .head_valid_o  (head_valid),
    .almost_full_o (fifo_almost_full)
  );

  tti_writer u_tti_writer (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .head_data_i            (head_data),
    .head_valid_i           (head_valid),
    .rx_queue_wready_i      (rx_queue_wready_i),
    .rx_desc_queue_wready_i (rx_desc_queue_wready_i),
    .pop_o                  (pop),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o)
  );

endmodule

`default_nettype wire

//--- design/rx_fifo.sv
// Show-ahead entry FIFO where the writer side must not push when full nor pop when empty
`timescale 1ns/10ps
`default_nettype none

module rx_fifo (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           push_i,
  input  logic [standby_pkg::EntryW-1:0] push_data_i,
  input  logic                           pop_i,
  output logic [standby_pkg::EntryW-1:0] head_data_o,
  output logic                           head_valid_o,
  output logic                           almost_full_o
);
  import standby_pkg::*;

  logic [EntryW-1:0]     mem_q [RxFifoDepth];
  logic [RxFifoPtrW-1:0] wr_ptr_q;
  logic [RxFifoPtrW-1:0] rd_ptr_q;
  logic [RxFifoPtrW:0]   count_q;

  function automatic logic [RxFifoPtrW-1:0] ptr_next(input logic [RxFifoPtrW-1:0] ptr);
    if (ptr == RxFifoPtrW'(RxFifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      unique case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_data_o   = mem_q[rd_ptr_q];
  assign head_valid_o  = (count_q != '0);
  // At most one slot left
  assign almost_full_o = (count_q >= (RxFifoPtrW + 1)'(RxFifoDepth - 1));

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count_q != (RxFifoPtrW + 1)'(RxFifoDepth)));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (count_q != '0));

endmodule

`default_nettype wire

//--- design/standby_pkg.sv
// Shared types and constants for the receive-only I2C standby target with no I3C support
`default_nettype none

package standby_pkg;

  // FIFO between the bus monitor and the TTI writer
  localparam int unsigned RxFifoDepth = 8;
  localparam int unsigned RxFifoPtrW = $clog2(RxFifoDepth);

  // Entry is one kind bit above an 8-bit payload
  localparam int unsigned EntryW = 9;

  typedef enum logic {
    ENTRY_DATA = 1'b0,
    ENTRY_END  = 1'b1
  } entry_kind_e;

  typedef enum logic [2:0] {
    MON_IDLE,
    MON_ADDR,
    MON_ADDR_ACK,
    MON_DATA,
    MON_DATA_ACK,
    MON_IGNORE
  } mon_state_e;

  // RX descriptor layout
  localparam int unsigned DescDataW = 32;
  localparam int unsigned DescAddrLsb = 0;
  localparam int unsigned DescCountLsb = 8;
  localparam int unsigned DescRefusedBit = 31;

endpackage

`default_nettype wire

//--- design/tti_writer.sv
// TTI writer that expects a header entry first in each transfer and wraps byte counts past 65535
`timescale 1ns/10ps
`default_nettype none

module tti_writer (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [standby_pkg::EntryW-1:0]    head_data_i,
  input  logic                              head_valid_i,
  input  logic                              rx_queue_wready_i,
  input  logic                              rx_desc_queue_wready_i,
  output logic                              pop_o,
  output logic                              rx_queue_wvalid_o,
  output logic [7:0]                        rx_queue_wdata_o,
  output logic                              rx_desc_queue_wvalid_o,
  output logic [standby_pkg::DescDataW-1:0] rx_desc_queue_wdata_o
);
  import standby_pkg::*;

  entry_kind_e head_kind;
  logic        is_data;
  logic        hdr_take;
  logic        data_take;
  logic        desc_take;

  logic        hdr_pending_q;
  logic [7:0]  addr_q;
  logic [15:0] count_q;

  logic [DescDataW-1:0] desc;

  assign head_kind = entry_kind_e'(head_data_i[EntryW-1]);
  assign is_data   = head_valid_i && (head_kind == ENTRY_DATA);

  // First data entry of a transfer is the header byte, held until the RX queue is ready
  assign hdr_take  = is_data && hdr_pending_q && rx_queue_wready_i;
  assign data_take = rx_queue_wvalid_o && rx_queue_wready_i;
  assign desc_take = rx_desc_queue_wvalid_o && rx_desc_queue_wready_i;

  assign rx_queue_wvalid_o      = is_data && !hdr_pending_q;
  assign rx_queue_wdata_o       = head_data_i[7:0];
  assign rx_desc_queue_wvalid_o = head_valid_i && (head_kind == ENTRY_END);
  assign pop_o                  = hdr_take || data_take || desc_take;

  always_comb begin
    desc                     = '0;
    desc[DescAddrLsb +: 8]   = addr_q;
    desc[DescCountLsb +: 16] = count_q;
    desc[DescRefusedBit]     = head_data_i[0];
  end

  assign rx_desc_queue_wdata_o = desc;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hdr_pending_q <= 1'b1;
      count_q       <= '0;
    end else begin
      if (hdr_take) begin
        hdr_pending_q <= 1'b0;
      end else if (desc_take) begin
        hdr_pending_q <= 1'b1;
      end
      if (desc_take) begin
        count_q <= '0;
      end else if (data_take) begin
        count_q <= count_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_take) begin
      addr_q <= head_data_i[7:0];
    end
  end

  a_rx_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rx_queue_wvalid_o && !rx_queue_wready_i) |=>
      (rx_queue_wvalid_o && $stable(rx_queue_wdata_o)));

endmodule

`default_nettype wire

//--- testbench/tb_controller_standby.sv
// Single I2C master at a fixed SCL rate, the RX path must drain faster than the bus unless stalled
`timescale 1ns/10ps
`default_nettype none

module tb_controller_standby;
  import standby_pkg::*;

  localparam int ClkPeriod = 20;
  localparam int Quarter = 8;
  localparam int ByteClks = 9 * 4 * Quarter;
  localparam int CondClks = 4 * Quarter;
  localparam int MaxLen = 6;
  localparam int PressLen = 12;
  localparam int NumRandom = 4;
  localparam int NumStall = 4;
  localparam int DrainClks = 200;
  localparam logic [31:0] Seed = 32'hddd3_a80a;
  // Every transfer at its longest, the back-pressure write and one read header
  localparam int TotalBytes = (NumRandom + NumStall + 2) * (1 + MaxLen) + (1 + PressLen) + 1;
  localparam int TotalConds = 2 * (NumRandom + NumStall) + 8;
  localparam int WatchdogClks = TotalBytes * ByteClks + TotalConds * CondClks
                                + 6 * DrainClks + 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        scl_m;
  logic        sda_m;
  logic        sda_bus;
  logic        ready_level;
  logic        stall_en;
  logic [31:0] rng_q;
  logic [31:0] stall_rng_q;
  logic        rx_queue_wready;
  logic        rx_desc_queue_wready;
  logic        ctrl_sda;
  logic        rx_queue_wvalid;
  logic [7:0]  rx_queue_wdata;
  logic        rx_desc_queue_wvalid;
  logic [31:0] rx_desc_queue_wdata;
  logic        bus_start;
  logic        bus_stop;
  logic [7:0]  bus_addr;
  logic        bus_addr_valid;

  logic [7:0]  exp_data_q[$];
  logic [31:0] exp_desc_q[$];
  logic [7:0]  exp_addr_q[$];
  int errors = 0;
  int err_base = 0;
  int checks = 0;
  int tests_run = 0;
  int starts_gen = 0;
  int stops_gen = 0;
  int starts_seen = 0;
  int stops_seen = 0;

  // Open-drain bus, either side can pull SDA low
  assign sda_bus = sda_m & ctrl_sda;
  assign rx_queue_wready      = stall_en ? stall_rng_q[4] : ready_level;
  assign rx_desc_queue_wready = stall_en ? stall_rng_q[9] : ready_level;

  always #(ClkPeriod / 2) clk = ~clk;

  controller_standby u_dut (
    .clk_i                  (clk),
    .rst_n_i                (rst_n),
    .ctrl_scl_i             (scl_m),
    .ctrl_sda_i             (sda_bus),
    .ctrl_sda_o             (ctrl_sda),
    .rx_queue_wvalid_o      (rx_queue_wvalid),
    .rx_queue_wready_i      (rx_queue_wready),
    .rx_queue_wdata_o       (rx_queue_wdata),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid),
    .rx_desc_queue_wready_i (rx_desc_queue_wready),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata),
    .bus_start_o            (bus_start),
    .bus_stop_o             (bus_stop),
    .bus_addr_o             (bus_addr),
    .bus_addr_valid_o       (bus_addr_valid)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] make_desc(input logic [7:0] addr, input int count,
                                            input logic refused);
    logic [31:0] desc;
    desc = '0;
    desc = desc | (32'(addr) << DescAddrLsb);
    desc = desc | (32'(count[15:0]) << DescCountLsb);
    desc = desc | (32'(refused) << DescRefusedBit);
    return desc;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_q = xorshift32(rng_q);
    value = rng_q;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic idle_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic drive_bit(input logic value);
    idle_clocks(Quarter);
    sda_m = value;
    idle_clocks(Quarter);
    scl_m = 1'b1;
    idle_clocks(2 * Quarter);
    scl_m = 1'b0;
  endtask

  task automatic shift_byte(input logic [7:0] value, output logic acked);
    for (int i = 7; i >= 0; i--) begin
      drive_bit(value[i]);
    end
    // Ninth bit, master releases SDA and reads the target's answer
    idle_clocks(Quarter);
    sda_m = 1'b1;
    idle_clocks(Quarter);
    scl_m = 1'b1;
    idle_clocks(Quarter);
    acked = !sda_bus;
    idle_clocks(Quarter);
    scl_m = 1'b0;
  endtask

  task automatic start_cond(input logic repeated);
    if (repeated) begin
      idle_clocks(Quarter);
      sda_m = 1'b1;
      idle_clocks(Quarter);
      scl_m = 1'b1;
    end
    idle_clocks(Quarter);
    sda_m = 1'b0;
    idle_clocks(Quarter);
    scl_m = 1'b0;
    starts_gen++;
  endtask

  task automatic stop_cond();
    idle_clocks(Quarter);
    sda_m = 1'b0;
    idle_clocks(Quarter);
    scl_m = 1'b1;
    idle_clocks(Quarter);
    sda_m = 1'b1;
    idle_clocks(Quarter);
    stops_gen++;
  endtask

  // Only the first n_accept data bytes are expected to be acknowledged
  task automatic write_transfer(input logic [6:0] addr, input int len, input int n_accept,
                                input logic repeated);
    logic [31:0] value;
    logic        acked;
    start_cond(repeated);
    exp_addr_q.push_back({addr, 1'b0});
    shift_byte({addr, 1'b0}, acked);
    check_value("write header ACK", 32'(acked), 32'd1);
    for (int i = 0; i < len; i++) begin
      next_random(value);
      if (i < n_accept) begin
        exp_data_q.push_back(value[7:0]);
      end
      shift_byte(value[7:0], acked);
      check_value("data ACK", 32'(acked), 32'(i < n_accept));
    end
    exp_desc_q.push_back(make_desc({addr, 1'b0}, (n_accept < len) ? n_accept : len,
                                   n_accept < len));
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_data_q.size() + exp_desc_q.size() + exp_addr_q.size()) != 0 &&
           waited < DrainClks) begin
      idle_clocks(1);
      waited++;
    end
    if ((exp_data_q.size() + exp_desc_q.size() + exp_addr_q.size()) != 0) begin
      $display("Timed out with %0d bytes, %0d descriptors and %0d headers never seen",
               exp_data_q.size(), exp_desc_q.size(), exp_addr_q.size());
      errors++;
      exp_data_q.delete();
      exp_desc_q.delete();
      exp_addr_q.delete();
    end
    // Room for any stray output to show up
    idle_clocks(10);
  endtask

  task automatic finish_test(input string name);
    if (errors == err_base) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - err_base);
    end
    err_base = errors;
    tests_run++;
  endtask

  task automatic drive_stalls();
    forever begin
      @(negedge clk);
      stall_rng_q = xorshift32(stall_rng_q);
    end
  endtask

  task automatic sample_outputs();
    logic [31:0] expected;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        if (bus_start) begin
          starts_seen++;
        end
        if (bus_stop) begin
          stops_seen++;
        end
        if (rx_queue_wvalid && rx_queue_wready) begin
          if (exp_data_q.size() == 0) begin
            $display("Unexpected byte 0x%0h on the RX data queue", rx_queue_wdata);
            errors++;
          end else begin
            expected = 32'(exp_data_q.pop_front());
            check_value("rx_queue_wdata_o", 32'(rx_queue_wdata), expected);
          end
        end
        if (rx_desc_queue_wvalid && rx_desc_queue_wready) begin
          if (exp_desc_q.size() == 0) begin
            $display("Unexpected descriptor 0x%0h on the RX descriptor queue",
                     rx_desc_queue_wdata);
            errors++;
          end else begin
            expected = exp_desc_q.pop_front();
            check_value("rx_desc_queue_wdata_o", rx_desc_queue_wdata, expected);
          end
        end
        if (bus_addr_valid) begin
          if (exp_addr_q.size() == 0) begin
            $display("Address 0x%0h reported with no header on the bus", bus_addr);
            errors++;
          end else begin
            expected = 32'(exp_addr_q.pop_front());
            check_value("bus_addr_o", 32'(bus_addr), expected);
          end
        end
      end
    end
  endtask

  initial begin
    #(WatchdogClks * ClkPeriod);
    $display("Watchdog expired after %0d clock cycles, the run did not finish", WatchdogClks);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [31:0] value;
    logic        acked;
    int          len;
    rst_n = 1'b0;
    scl_m = 1'b1;
    sda_m = 1'b1;
    ready_level = 1'b1;
    stall_en = 1'b0;
    rng_q = Seed;
    stall_rng_q = ~Seed;
    fork
      sample_outputs();
      drive_stalls();
    join_none
    idle_clocks(3);
    rst_n = 1'b1;

    idle_clocks(2);
    check_value("rx_queue_wvalid_o", 32'(rx_queue_wvalid), 32'd0);
    check_value("rx_desc_queue_wvalid_o", 32'(rx_desc_queue_wvalid), 32'd0);
    check_value("bus_start_o", 32'(bus_start), 32'd0);
    check_value("bus_stop_o", 32'(bus_stop), 32'd0);
    check_value("bus_addr_valid_o", 32'(bus_addr_valid), 32'd0);
    check_value("ctrl_sda_o", 32'(ctrl_sda), 32'd1);
    finish_test("1 reset state");

    repeat (NumRandom) begin
      next_random(value);
      len = 1 + int'(value[15:8]) % MaxLen;
      write_transfer(value[6:0], len, len, 1'b0);
      stop_cond();
      wait_drain();
    end
    finish_test("2 random writes");

    next_random(value);
    start_cond(1'b0);
    exp_addr_q.push_back({value[6:0], 1'b1});
    shift_byte({value[6:0], 1'b1}, acked);
    check_value("read header ACK", 32'(acked), 32'd0);
    stop_cond();
    wait_drain();
    finish_test("3 read header");

    // Header and data fill every slot except the one kept for END
    ready_level = 1'b0;
    idle_clocks(4);
    next_random(value);
    write_transfer(value[6:0], PressLen, int'(RxFifoDepth) - 2, 1'b0);
    stop_cond();
    idle_clocks(50);
    ready_level = 1'b1;
    wait_drain();
    finish_test("4 back-pressure");

    next_random(value);
    len = 1 + int'(value[15:8]) % MaxLen;
    write_transfer(value[6:0], len, len, 1'b0);
    next_random(value);
    len = 1 + int'(value[15:8]) % MaxLen;
    write_transfer(value[6:0], len, len, 1'b1);
    stop_cond();
    wait_drain();
    finish_test("5 repeated START");

    stall_en = 1'b1;
    repeat (NumStall) begin
      next_random(value);
      len = 1 + int'(value[15:8]) % MaxLen;
      write_transfer(value[6:0], len, len, 1'b0);
      stop_cond();
      wait_drain();
    end
    stall_en = 1'b0;
    check_value("bus_start_o pulse count", 32'(starts_seen), 32'(starts_gen));
    check_value("bus_stop_o pulse count", 32'(stops_seen), 32'(stops_gen));
    finish_test("6 random stalls");

    $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/standby_pkg.sv
design/bus_monitor.sv
design/rx_fifo.sv
design/tti_writer.sv
design/controller_standby.sv
testbench/tb_controller_standby.sv
